//--- list.f
+incdir+include
design/f8_pkg.sv
design/alu_if.sv
design/f8_alu.sv
design/f8_regfile.sv
design/f8_fetch.sv
design/f8_control.sv
design/f8_core.sv
verification/f8_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert -j 0
TOP ?= f8_core_tb
FILELIST ?= list.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- include/f8_tb_model.svh
/* instruction-level model; include inside a module body, refers to f8_pkg by scope
   f8_model_step updates state and model memory in place and returns the expected outputs */
`ifndef F8_TB_MODEL_SVH
`define F8_TB_MODEL_SVH

typedef logic [7:0] f8_mem_t [0:65535];

typedef struct {
	logic [15:0] pc;
	logic [15:0] x;
	logic [15:0] y;
	logic [15:0] z;
	f8_pkg::flags_t flags;
} f8_model_state_t;

typedef struct {
	logic [15:0] next_pc;
	logic [1:0] wen;
	logic [15:0] waddr;
	logic [15:0] wdata;
	logic trap;
} f8_model_out_t;

function automatic f8_model_out_t f8_model_step(ref f8_model_state_t st, ref f8_mem_t mem,
	input logic [23:0] iw);
	f8_model_out_t o;
	logic [7:0] opc;
	logic [7:0] imm8;
	logic [15:0] imm16;
	logic [15:0] len;
	logic dir;
	logic [15:0] w;
	logic [8:0] r;
	logic wr_xl;
	logic take;

	opc = iw[7:0];
	imm8 = iw[15:8];
	imm16 = iw[23:8];
	// byte count from the operand kind
	case (opc)
		f8_pkg::OP_LD_XL_IMM, f8_pkg::OP_ADD_XL_IMM, f8_pkg::OP_SUB_XL_IMM,
		f8_pkg::OP_AND_XL_IMM, f8_pkg::OP_OR_XL_IMM, f8_pkg::OP_XOR_XL_IMM,
		f8_pkg::OP_JR, f8_pkg::OP_JRZ, f8_pkg::OP_JRNZ, f8_pkg::OP_JRC, f8_pkg::OP_JRNC:
			len = 16'd2;
		f8_pkg::OP_LDW_Y_IMM, f8_pkg::OP_LDW_Z_IMM, f8_pkg::OP_JP_IMM,
		f8_pkg::OP_LD_XL_DIR, f8_pkg::OP_LD_DIR_XL,
		f8_pkg::OP_LDW_Y_DIR, f8_pkg::OP_LDW_DIR_Y:
			len = 16'd3;
		default:
			len = 16'd1;
	endcase
	dir = (opc == f8_pkg::OP_LD_XL_DIR) || (opc == f8_pkg::OP_LDW_Y_DIR);
	w = dir ? {mem[imm16 + 16'd1], mem[imm16]} : imm16;
	o = '{next_pc: st.pc + len, wen: 2'b00, waddr: imm16, wdata: 16'h0000, trap: 1'b0};
	wr_xl = 1'b1;
	take = 1'b0;
	// r holds carry and result; logic ops and loads keep the carry
	case (opc)
		f8_pkg::OP_LD_XL_IMM, f8_pkg::OP_LD_XL_DIR: r = {st.flags.c, w[7:0]};
		f8_pkg::OP_ADD_XL_IMM: r = {1'b0, st.x[7:0]} + {1'b0, imm8};
		f8_pkg::OP_SUB_XL_IMM: r = {st.x[7:0] >= imm8, st.x[7:0] - imm8};
		f8_pkg::OP_AND_XL_IMM: r = {st.flags.c, st.x[7:0] & imm8};
		f8_pkg::OP_OR_XL_IMM: r = {st.flags.c, st.x[7:0] | imm8};
		f8_pkg::OP_XOR_XL_IMM: r = {st.flags.c, st.x[7:0] ^ imm8};
		f8_pkg::OP_ADD_XL_YL: r = {1'b0, st.x[7:0]} + {1'b0, st.y[7:0]};
		f8_pkg::OP_INC_XL: r = {1'b0, st.x[7:0]} + 9'd1;
		default:
		begin
			r = 9'h000;
			wr_xl = 1'b0;
		end
	endcase
	if (wr_xl)
	begin
		st.x[7:0] = r[7:0];
		st.flags = '{c: r[8], z: (r[7:0] == 8'h00), n: r[7]};
	end
	case (opc)
		f8_pkg::OP_LDW_Y_IMM, f8_pkg::OP_LDW_Y_DIR: st.y = w;
		f8_pkg::OP_LDW_Z_IMM: st.z = w;
		f8_pkg::OP_LD_DIR_XL:
		begin
			o.wen = 2'b01;
			o.wdata = {8'h00, st.x[7:0]};
		end
		f8_pkg::OP_LDW_DIR_Y:
		begin
			o.wen = 2'b11;
			o.wdata = st.y;
		end
		f8_pkg::OP_TRAP: o.trap = 1'b1;
		f8_pkg::OP_JP_IMM: o.next_pc = imm16;
		f8_pkg::OP_JR: take = 1'b1;
		f8_pkg::OP_JRZ: take = st.flags.z;
		f8_pkg::OP_JRNZ: take = !st.flags.z;
		f8_pkg::OP_JRC: take = st.flags.c;
		f8_pkg::OP_JRNC: take = !st.flags.c;
		default: take = 1'b0;
	endcase
	if (opc == f8_pkg::OP_LDW_Y_IMM || opc == f8_pkg::OP_LDW_Z_IMM ||
		opc == f8_pkg::OP_LDW_Y_DIR)
	begin
		st.flags.z = (w == 16'h0000);
		st.flags.n = w[15];
	end
	if (take)
		o.next_pc = st.pc + {{8{imm8[7]}}, imm8};
	if (o.wen[0])
		mem[imm16] = o.wdata[7:0];
	if (o.wen[1])
		mem[imm16 + 16'd1] = o.wdata[15:8];
	st.pc = o.next_pc;
	return o;
endfunction

`endif

//--- verification/f8_core_tb.sv
/* runs fixed and random programs from 0x4000 against an instruction-level model
   both memories answer one cycle after the address; data memory is write-first */
`timescale 1ns/1ps
`default_nettype none

module f8_core_tb;
	import f8_pkg::*;

	`include "f8_tb_model.svh"

	localparam logic [15:0] start_addr = 16'h4000;

	logic clk;
	logic reset;
	logic [15:0] iread_addr;
	logic [23:0] iread_data;
	logic [15:0] dread_addr;
	logic [15:0] dread_data;
	logic [15:0] dwrite_addr;
	logic [15:0] dwrite_data;
	logic [1:0] dwrite_en;
	logic trap;

	logic [7:0] imem [0:65535];
	logic [7:0] dmem [0:65535];
	f8_mem_t model_mem;
	f8_model_state_t st;
	f8_model_out_t expect_out;

	logic [15:0] wp;
	logic [15:0] end_addr;
	logic [15:0] prev_iaddr;
	logic [15:0] slot;
	logic [7:0] next_op;
	logic [31:0] rng;
	int n_inst;
	int steps;
	int limit_cycles;
	int checks;
	int errors;

	f8_core #(
		.RESET_VECTOR(start_addr)
	) f8_core_inst (
		.clk(clk),
		.reset(reset),
		.iread_addr(iread_addr),
		.iread_data(iread_data),
		.dread_addr(dread_addr),
		.dread_data(dread_data),
		.dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data),
		.dwrite_en(dwrite_en),
		.trap(trap)
	);

	always #50 clk = !clk;

	// a load right after a store to the same byte sees the new value
	always @(posedge clk)
	begin : memories
		logic [15:0] ia;
		logic [15:0] da;
		if (dwrite_en[0] === 1'b1)
			dmem[dwrite_addr] = dwrite_data[7:0];
		if (dwrite_en[1] === 1'b1)
			dmem[dwrite_addr + 16'd1] = dwrite_data[15:8];
		ia = iread_addr;
		da = dread_addr;
		#1;
		iread_data <= {imem[ia + 16'd2], imem[ia + 16'd1], imem[ia]};
		dread_data <= {dmem[da + 16'd1], dmem[da]};
	end

	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] want);
		checks++;
		if (got !== want)
		begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, want);
		end
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] v;
		v = s ^ (s << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	task automatic emit1(input logic [7:0] op);
		imem[wp] = op;
		wp = wp + 16'd1;
		n_inst++;
	endtask

	task automatic emit_b(input logic [7:0] op, input logic [7:0] b);
		imem[wp] = op;
		imem[wp + 16'd1] = b;
		wp = wp + 16'd2;
		n_inst++;
	endtask

	task automatic emit_w(input logic [7:0] op, input logic [15:0] w);
		imem[wp] = op;
		imem[wp + 16'd1] = w[7:0];
		imem[wp + 16'd2] = w[15:8];
		wp = wp + 16'd3;
		n_inst++;
	endtask

	task automatic preload(input logic [15:0] a, input logic [7:0] v);
		dmem[a] = v;
		model_mem[a] = v;
	endtask

	task automatic store_xl();
		emit_w(OP_LD_DIR_XL, slot);
		slot = slot + 16'd1;
	endtask

	// offset 5 lands just past the 3-byte store
	task automatic skip_store(input logic [7:0] op);
		emit_b(op, 8'h05);
		store_xl();
	endtask

	// forward over the middle jump, back to it, then out past all three
	task automatic jump_triangle(input logic [7:0] op);
		emit_b(op, 8'h04);
		emit_b(op, 8'h04);
		emit_b(op, 8'hfe);
	endtask

	task automatic alu_program();
		emit_w(OP_LDW_Y_IMM, 16'h80c3);
		emit_b(OP_LD_XL_IMM, 8'h7f);
		emit_b(OP_ADD_XL_IMM, 8'h01);
		store_xl();
		emit_b(OP_SUB_XL_IMM, 8'h90);
		store_xl();
		skip_store(OP_JRC);
		emit_b(OP_SUB_XL_IMM, 8'h70);
		store_xl();
		skip_store(OP_JRC);
		emit_b(OP_AND_XL_IMM, 8'h0f);
		store_xl();
		skip_store(OP_JRZ);
		emit_b(OP_OR_XL_IMM, 8'h5a);
		store_xl();
		emit_b(OP_XOR_XL_IMM, 8'hff);
		store_xl();
		skip_store(OP_JRNZ);
		emit1(OP_ADD_XL_YL);
		store_xl();
		emit1(OP_INC_XL);
		store_xl();
		emit1(8'h7e);
		emit_b(OP_LD_XL_IMM, 8'hff);
		emit1(OP_INC_XL);
		skip_store(OP_JRNC);
		skip_store(OP_JRC);
	endtask

	// words straddle page ends at 0x12ff and 0x20ff
	task automatic load_store_program();
		preload(16'h12fe, 8'h34);
		preload(16'h12ff, 8'h92);
		emit_w(OP_LDW_Y_IMM, 16'hbeef);
		emit_w(OP_LDW_DIR_Y, 16'h20ff);
		emit_w(OP_LD_XL_DIR, 16'h12ff);
		emit_w(OP_LDW_Y_DIR, 16'h12fe);
		emit_w(OP_LDW_DIR_Y, 16'h0200);
		emit_w(OP_LD_DIR_XL, 16'h0202);
		emit_w(OP_LD_XL_DIR, 16'h20ff);
		emit_w(OP_LDW_Y_DIR, 16'h20ff);
		emit_w(OP_LDW_DIR_Y, 16'h0204);
		emit_w(OP_LDW_Z_IMM, 16'h0000);
		emit_b(OP_JRNZ, 8'hf0);
		emit_w(OP_LDW_Y_IMM, 16'h0000);
		skip_store(OP_JRZ);
	endtask

	task automatic branch_program();
		// the store after jp must never execute
		emit_w(OP_JP_IMM, wp + 16'd6);
		store_xl();
		emit_b(OP_LD_XL_IMM, 8'hff);
		emit_b(OP_ADD_XL_IMM, 8'h01);
		jump_triangle(OP_JR);
		jump_triangle(OP_JRZ);
		jump_triangle(OP_JRC);
		emit_b(OP_JRNZ, 8'hf8);
		emit_b(OP_JRNC, 8'h06);
		// 0 - 1 borrows, so c and z clear
		emit_b(OP_SUB_XL_IMM, 8'h01);
		jump_triangle(OP_JRNZ);
		jump_triangle(OP_JRNC);
		emit_b(OP_JRZ, 8'h06);
		emit_b(OP_JRC, 8'hf8);
	endtask

	task automatic random_program();
		logic [7:0] b;
		logic [15:0] a;
		rng = xorshift(rng);
		emit_b(OP_LD_XL_IMM, rng[7:0]);
		emit_w(OP_LDW_Y_IMM, rng[31:16]);
		for (int i = 0; i < 10; i++)
		begin
			rng = xorshift(rng);
			b = rng[15:8];
			// small window so loads often hit earlier stores
			a = 16'h0300 + {11'd0, rng[20:16]};
			case (rng[27:24] % 4'd14)
				4'd0: emit_b(OP_LD_XL_IMM, b);
				4'd1: emit_b(OP_ADD_XL_IMM, b);
				4'd2: emit_b(OP_SUB_XL_IMM, b);
				4'd3: emit_b(OP_AND_XL_IMM, b);
				4'd4: emit_b(OP_OR_XL_IMM, b);
				4'd5: emit_b(OP_XOR_XL_IMM, b);
				4'd6: emit1(OP_ADD_XL_YL);
				4'd7: emit1(OP_INC_XL);
				4'd8: emit_w(OP_LD_XL_DIR, a);
				4'd9: emit_w(OP_LD_DIR_XL, a);
				4'd10: emit_w(OP_LDW_Y_DIR, a);
				4'd11: emit_w(OP_LDW_DIR_Y, a);
				4'd12: emit_w(OP_LDW_Y_IMM, {b, rng[7:0]});
				default: emit_w(OP_LDW_Z_IMM, {b, rng[7:0]});
			endcase
		end
		emit1(OP_TRAP);
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		iread_data = '0;
		dread_data = '0;
		rng = 32'haf15;
		checks = 0;
		errors = 0;
		n_inst = 0;
		steps = 0;
		limit_cycles = 0;
		slot = 16'h0100;
		for (int a = 0; a < 65536; a++)
		begin
			imem[a] = 8'h00;
			dmem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'ha5;
			model_mem[a] = dmem[a];
		end
		wp = start_addr;
		alu_program();
		load_store_program();
		branch_program();
		for (int i = 0; i < 8; i++)
			random_program();
		emit1(OP_TRAP);
		emit1(OP_TRAP);
		emit1(OP_NOP);
		emit1(OP_TRAP);
		end_addr = wp;
		emit_b(OP_JR, 8'h00);
		limit_cycles = n_inst + 112;
		st = '{pc: start_addr, x: 16'h0000, y: 16'h0000, z: 16'h0000, flags: 3'b000};

		repeat (10)
		begin
			@(negedge clk);
			check_value("iread_addr", iread_addr, start_addr);
			check_value("dwrite_en", 16'(dwrite_en), 16'h0000);
			check_value("trap", 16'(trap), 16'h0000);
		end
		@(posedge clk);
		#1 reset = 1'b0;

		// iread_addr runs one cycle ahead of the executing instruction
		@(negedge clk);
		prev_iaddr = iread_addr;
		while (st.pc != end_addr)
		begin
			@(negedge clk);
			expect_out = f8_model_step(st, model_mem,
				{imem[st.pc + 16'd2], imem[st.pc + 16'd1], imem[st.pc]});
			steps++;
			check_value("iread_addr", prev_iaddr, expect_out.next_pc);
			check_value("dwrite_en", 16'(dwrite_en), 16'(expect_out.wen));
			if (expect_out.wen != 2'b00)
			begin
				check_value("dwrite_addr", dwrite_addr, expect_out.waddr);
				check_value("dwrite_data", dwrite_data, expect_out.wdata);
			end
			check_value("trap", 16'(trap), 16'(expect_out.trap));
			// the word arriving now is the next instruction
			next_op = imem[st.pc];
			if (next_op == OP_LD_XL_DIR || next_op == OP_LDW_Y_DIR)
				check_value("dread_addr", dread_addr,
					{imem[st.pc + 16'd2], imem[st.pc + 16'd1]});
			prev_iaddr = iread_addr;
		end

		$display("%0d instructions executed, %0d checks, %0d errors", steps, checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("timeout: the programs did not finish within %0d cycles", limit_cycles);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- design/f8_core.sv
/* both memories must be synchronous with one cycle of latency, no stalls
   one instruction per cycle; fetch and execute overlap */
`timescale 1ns/1ps
`default_nettype none

module f8_core #(
	parameter logic [f8_pkg::addr_w-1:0] RESET_VECTOR = f8_pkg::reset_vector_default
) (
	input wire clk,
	input wire reset,
	output logic [f8_pkg::addr_w-1:0] iread_addr,
	input wire [f8_pkg::inst_w-1:0] iread_data,
	output logic [f8_pkg::addr_w-1:0] dread_addr,
	input wire [f8_pkg::addr_w-1:0] dread_data,
	output logic [f8_pkg::addr_w-1:0] dwrite_addr,
	output logic [f8_pkg::addr_w-1:0] dwrite_data,
	output logic [1:0] dwrite_en,
	output logic trap
);
	import f8_pkg::*;

	logic [inst_w-1:0] inst;
	logic [addr_w-1:0] x;
	logic [addr_w-1:0] y;
	logic [1:0] reg_addr;
	logic [addr_w-1:0] reg_data;
	logic [1:0] reg_byte_en;
	flags_t next_flags;

	alu_if alu_bus ();

	f8_fetch #(
		.RESET_VECTOR(RESET_VECTOR)
	) fetch_inst (
		.clk(clk),
		.reset(reset),
		.iread_data(iread_data),
		.next_flags(next_flags),
		.iread_addr(iread_addr),
		.dread_addr(dread_addr),
		.inst(inst)
	);

	f8_control control_inst (
		.clk(clk),
		.reset(reset),
		.inst(inst),
		.x(x),
		.y(y),
		.dread_data(dread_data),
		.reg_addr(reg_addr),
		.reg_data(reg_data),
		.reg_byte_en(reg_byte_en),
		.dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data),
		.dwrite_en(dwrite_en),
		.next_flags(next_flags),
		.trap(trap),
		.alu(alu_bus)
	);

	// z is written by ldw z but read by no kept instruction
	f8_regfile regfile_inst (
		.clk(clk),
		.reg_addr(reg_addr),
		.reg_data(reg_data),
		.reg_byte_en(reg_byte_en),
		.x(x),
		.y(y),
		.z()
	);

	f8_alu alu_inst (
		.alu(alu_bus)
	);

endmodule

`default_nettype wire

//--- design/f8_control.sv
/* dread_data must carry the operand of a direct read in its execute cycle
   stores write the low byte at dwrite_addr and the high byte at dwrite_addr+1 */
`timescale 1ns/1ps
`default_nettype none

module f8_control (
	input wire clk,
	input wire reset,
	input wire [f8_pkg::inst_w-1:0] inst,
	input wire [f8_pkg::addr_w-1:0] x,
	input wire [f8_pkg::addr_w-1:0] y,
	input wire [f8_pkg::addr_w-1:0] dread_data,
	output logic [1:0] reg_addr,
	output logic [f8_pkg::addr_w-1:0] reg_data,
	output logic [1:0] reg_byte_en,
	output logic [f8_pkg::addr_w-1:0] dwrite_addr,
	output logic [f8_pkg::addr_w-1:0] dwrite_data,
	output logic [1:0] dwrite_en,
	output f8_pkg::flags_t next_flags,
	output logic trap,
	alu_if.control alu
);
	import f8_pkg::*;

	logic [7:0] opcode;
	logic [7:0] imm8;
	logic [addr_w-1:0] imm16;
	logic [addr_w-1:0] word_val;
	flags_t flags;
	logic xl_write;
	logic word_load;

	assign opcode = inst[7:0];
	assign imm8 = inst[15:8];
	assign imm16 = inst[23:8];

	always_comb
	begin
		alu.op = ALU_PASS;
		xl_write = 1'b0;
		word_load = 1'b0;
		reg_addr = 2'd0;
		dwrite_en = 2'b00;
		trap = 1'b0;
		case (opcode)
			OP_TRAP:
				trap = 1'b1;
			OP_LD_XL_IMM, OP_LD_XL_DIR:
				xl_write = 1'b1;
			OP_ADD_XL_IMM, OP_ADD_XL_YL:
			begin
				alu.op = ALU_ADD;
				xl_write = 1'b1;
			end
			OP_SUB_XL_IMM:
			begin
				alu.op = ALU_SUB;
				xl_write = 1'b1;
			end
			OP_AND_XL_IMM:
			begin
				alu.op = ALU_AND;
				xl_write = 1'b1;
			end
			OP_OR_XL_IMM:
			begin
				alu.op = ALU_OR;
				xl_write = 1'b1;
			end
			OP_XOR_XL_IMM:
			begin
				alu.op = ALU_XOR;
				xl_write = 1'b1;
			end
			OP_INC_XL:
			begin
				alu.op = ALU_INC;
				xl_write = 1'b1;
			end
			OP_LDW_Y_IMM, OP_LDW_Y_DIR:
			begin
				word_load = 1'b1;
				reg_addr = 2'd1;
			end
			OP_LDW_Z_IMM:
			begin
				word_load = 1'b1;
				reg_addr = 2'd2;
			end
			OP_LD_DIR_XL:
				dwrite_en = 2'b01;
			OP_LDW_DIR_Y:
				dwrite_en = 2'b11;
			default:
				alu.op = ALU_PASS;
		endcase
	end

	// operand b: yl, read data or the immediate
	assign alu.a = x[7:0];
	assign alu.b = (opcode == OP_ADD_XL_YL) ? y[7:0] :
		is_dir_read(opcode) ? dread_data[7:0] : imm8;
	assign alu.c_in = flags.c;

	assign word_val = is_dir_read(opcode) ? dread_data : imm16;

	assign reg_data = word_load ? word_val : {8'h00, alu.result};
	assign reg_byte_en = word_load ? 2'b11 : {1'b0, xl_write};

	assign dwrite_addr = imm16;
	assign dwrite_data = dwrite_en[1] ? y : {8'h00, x[7:0]};

	// pass and logic ops come back with carry unchanged
	always_comb
	begin
		next_flags = flags;
		if (xl_write)
			next_flags = alu.flags_out;
		else if (word_load)
		begin
			next_flags.z = (word_val == '0);
			next_flags.n = word_val[15];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else
			flags <= next_flags;
	end

	a_no_high_byte_only: assert property (@(posedge clk) dwrite_en != 2'b10);

	// relies on fetch loading a nop while reset is high
	a_no_reg_write_in_reset: assert property (@(posedge clk)
		reset |-> (reg_byte_en == 2'b00));

endmodule

`default_nettype wire

//--- design/f8_fetch.sv
/* needs instruction memory with exactly one cycle of read latency and no wait states
   iread_addr and dread_addr are combinational from iread_data and next_flags */
`timescale 1ns/1ps
`default_nettype none

module f8_fetch #(
	parameter logic [f8_pkg::addr_w-1:0] RESET_VECTOR = f8_pkg::reset_vector_default
) (
	input wire clk,
	input wire reset,
	input wire [f8_pkg::inst_w-1:0] iread_data,
	input wire f8_pkg::flags_t next_flags,
	output logic [f8_pkg::addr_w-1:0] iread_addr,
	output logic [f8_pkg::addr_w-1:0] dread_addr,
	output logic [f8_pkg::inst_w-1:0] inst
);
	import f8_pkg::*;

	// address of the word now arriving on iread_data
	logic [addr_w-1:0] pc;
	logic [addr_w-1:0] next_pc;
	logic [7:0] arriving_op;
	logic [addr_w-1:0] imm16;
	logic [addr_w-1:0] jr_target;
	logic jr_cond;

	assign arriving_op = iread_data[7:0];
	assign imm16 = iread_data[23:8];
	assign jr_target = pc + {{8{iread_data[15]}}, iread_data[15:8]};

	// flags as left by the instruction executing right now
	always_comb
	begin
		case (arriving_op)
			OP_JRZ: jr_cond = next_flags.z;
			OP_JRNZ: jr_cond = !next_flags.z;
			OP_JRC: jr_cond = next_flags.c;
			OP_JRNC: jr_cond = !next_flags.c;
			default: jr_cond = 1'b1;
		endcase
	end

	always_comb
	begin
		if (reset)
			next_pc = RESET_VECTOR;
		else if (arriving_op == OP_JP_IMM)
			next_pc = imm16;
		else if (is_jr(arriving_op) && jr_cond)
			next_pc = jr_target;
		else
			next_pc = pc + addr_w'(opcode_length(arriving_op));
	end

	assign iread_addr = next_pc;

	// data arrives one cycle later, in the execute cycle
	assign dread_addr = is_dir_read(arriving_op) ? imm16 : '0;

	always_ff @(posedge clk)
	begin
		pc <= next_pc;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			inst <= inst_w'(OP_NOP);
		else
			inst <= iread_data;
	end

	a_reset_fetch_addr: assert property (@(posedge clk)
		reset |-> (iread_addr == RESET_VECTOR));

endmodule

`default_nettype wire

//--- design/f8_regfile.sv
/* x, y and z with a byte write enable each; no reset, contents unknown until written
   address 3 holds no register */
`timescale 1ns/1ps
`default_nettype none

module f8_regfile (
	input wire clk,
	input wire [1:0] reg_addr,
	input wire [f8_pkg::addr_w-1:0] reg_data,
	input wire [1:0] reg_byte_en,
	output logic [f8_pkg::addr_w-1:0] x,
	output logic [f8_pkg::addr_w-1:0] y,
	output logic [f8_pkg::addr_w-1:0] z
);
	import f8_pkg::*;

	logic [addr_w-1:0] regs [3];

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 3; i++)
		begin
			if (reg_addr == 2'(i))
			begin
				if (reg_byte_en[0])
					regs[i][7:0] <= reg_data[7:0];
				if (reg_byte_en[1])
					regs[i][15:8] <= reg_data[15:8];
			end
		end
	end

	assign x = regs[0];
	assign y = regs[1];
	assign z = regs[2];

	// decode in control never targets the missing fourth register
	a_no_reg3_write: assert property (@(posedge clk)
		(reg_byte_en != 2'b00) |-> (reg_addr != 2'd3));

endmodule

`default_nettype wire

//--- design/f8_alu.sv
/* 8-bit ALU, combinational
   sub sets carry when no borrow occurs; pass and logic ops keep the carry from c_in */
`timescale 1ns/1ps
`default_nettype none

module f8_alu (
	alu_if.alu alu
);
	import f8_pkg::*;

	logic [7:0] addend;
	logic add_cin;
	logic [8:0] sum;
	logic [7:0] res;
	logic carry;

	// one adder serves add, sub and inc
	assign addend = (alu.op == ALU_SUB) ? ~alu.b :
		(alu.op == ALU_INC) ? 8'h00 : alu.b;
	assign add_cin = (alu.op == ALU_SUB) || (alu.op == ALU_INC);
	assign sum = {1'b0, alu.a} + {1'b0, addend} + {8'h00, add_cin};

	always_comb
	begin
		res = alu.b;
		carry = alu.c_in;
		case (alu.op)
			ALU_ADD, ALU_SUB, ALU_INC:
			begin
				res = sum[7:0];
				carry = sum[8];
			end
			ALU_AND:
				res = alu.a & alu.b;
			ALU_OR:
				res = alu.a | alu.b;
			ALU_XOR:
				res = alu.a ^ alu.b;
			default:
				res = alu.b;
		endcase
	end

	assign alu.result = res;
	assign alu.flags_out = '{c: carry, z: (res == 8'h00), n: res[7]};

endmodule

`default_nettype wire

//--- design/alu_if.sv
/* combinational link between control and ALU, no handshake
   result and flags_out follow the operands within the same cycle */
`timescale 1ns/1ps
`default_nettype none

interface alu_if;
	import f8_pkg::*;

	aluop_t op;
	logic [7:0] a;
	logic [7:0] b;
	logic c_in;
	logic [7:0] result;
	flags_t flags_out;

	modport control (
		output op,
		output a,
		output b,
		output c_in,
		input result,
		input flags_out
	);

	modport alu (
		input op,
		input a,
		input b,
		input c_in,
		output result,
		output flags_out
	);

endinterface

`default_nettype wire

//--- design/f8_pkg.sv
/* opcode bytes missing from opcode_t execute as nop
   instruction word is little-endian: byte 0 opcode, bytes 1..2 immediate or address */
`default_nettype none

package f8_pkg;

	localparam int addr_w = 16;
	localparam int inst_w = 24;
	localparam logic [addr_w-1:0] reset_vector_default = 16'h4000;

	typedef enum logic [7:0] {
		OP_NOP = 8'h00,
		OP_TRAP = 8'h01,
		OP_LD_XL_IMM = 8'h10,
		OP_LDW_Y_IMM = 8'h11,
		OP_LDW_Z_IMM = 8'h12,
		OP_ADD_XL_IMM = 8'h20,
		OP_SUB_XL_IMM = 8'h21,
		OP_AND_XL_IMM = 8'h22,
		OP_OR_XL_IMM = 8'h23,
		OP_XOR_XL_IMM = 8'h24,
		OP_ADD_XL_YL = 8'h28,
		OP_INC_XL = 8'h29,
		OP_LD_XL_DIR = 8'h30,
		OP_LD_DIR_XL = 8'h31,
		OP_LDW_Y_DIR = 8'h32,
		OP_LDW_DIR_Y = 8'h33,
		OP_JP_IMM = 8'h40,
		OP_JR = 8'h41,
		OP_JRZ = 8'h42,
		OP_JRNZ = 8'h43,
		OP_JRC = 8'h44,
		OP_JRNC = 8'h45
	} opcode_t;

	typedef enum logic [3:0] {
		ALU_PASS,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_INC
	} aluop_t;

	typedef struct packed {
		logic c;
		logic z;
		logic n;
	} flags_t;

	// length in bytes, unknown opcodes count as nop
	function automatic logic [1:0] opcode_length(input logic [7:0] opc);
		case (opc)
			OP_LD_XL_IMM, OP_ADD_XL_IMM, OP_SUB_XL_IMM, OP_AND_XL_IMM, OP_OR_XL_IMM,
			OP_XOR_XL_IMM, OP_JR, OP_JRZ, OP_JRNZ, OP_JRC, OP_JRNC:
				return 2'd2;
			OP_LDW_Y_IMM, OP_LDW_Z_IMM, OP_LD_XL_DIR, OP_LD_DIR_XL, OP_LDW_Y_DIR,
			OP_LDW_DIR_Y, OP_JP_IMM:
				return 2'd3;
			default:
				return 2'd1;
		endcase
	endfunction

	function automatic logic is_dir_read(input logic [7:0] opc);
		return (opc == OP_LD_XL_DIR) || (opc == OP_LDW_Y_DIR);
	endfunction

	function automatic logic is_jr(input logic [7:0] opc);
		return (opc >= OP_JR) && (opc <= OP_JRNC);
	endfunction

endpackage

`default_nettype wire
